/* include/usb_pkt_consts.svh */
`ifndef USB_PKT_CONSTS_SVH
`define USB_PKT_CONSTS_SVH

// endpoint buffer address width
`define USB_BUF_AW 9

// bytes beyond this index are dropped and never written
`define USB_MAX_PAYLOAD 512

// byte counter and commit length
`define USB_LEN_W 11

// device address and endpoint field widths of a token
`define USB_DEV_AW 7
`define USB_EP_W 4

// crc registers start from all ones
`define USB_CRC5_INIT 5'h1f
`define USB_CRC16_INIT 16'hffff

// reflected polynomials for the lsb-first shift
`define USB_CRC5_POLY 5'h14
`define USB_CRC16_POLY 16'ha001

// ulpi transmit command in the upper nibble of a tx byte
`define ULPI_TXCMD 4'h4

`endif

/* hw/usb_pkt_pkg.sv */
`include "usb_pkt_consts.svh"

package usb_pkt_pkg;

	typedef logic [7:0] usb_byte_t;

	// pid values as they sit in the low nibble of the pid byte
	typedef enum logic [3:0] {
		PID_LPM    = 4'b0000,
		PID_OUT    = 4'b0001,
		PID_ACK    = 4'b0010,
		PID_DATA0  = 4'b0011,
		PID_PING   = 4'b0100,
		PID_SOF    = 4'b0101,
		PID_NYET   = 4'b0110,
		PID_DATA2  = 4'b0111,
		PID_SPLIT  = 4'b1000,
		PID_IN     = 4'b1001,
		PID_NAK    = 4'b1010,
		PID_DATA1  = 4'b1011,
		PID_PREERR = 4'b1100,
		PID_SETUP  = 4'b1101,
		PID_STALL  = 4'b1110,
		PID_DATAM  = 4'b1111
	} pid_t;

	typedef enum logic [2:0] {
		KIND_UNDEF = 3'd0,
		KIND_TOKEN = 3'd1,
		KIND_DATA  = 3'd2,
		KIND_HAND  = 3'd3,
		KIND_SPEC  = 3'd4
	} pkt_kind_t;

	typedef struct packed {
		logic [`USB_DEV_AW-1:0] addr;
		logic [`USB_EP_W-1:0]   endp;
	} token_t;

endpackage

/* hw/usb_rx_if.sv */
interface usb_rx_if;

	// ulpi receive stream
	logic act;
	usb_pkt_pkg::usb_byte_t data;
	logic latch;

	// which parser owns the bytes after the pid
	logic cap_token;
	logic cap_data;

	modport ctrl (
		input  act,
		input  data,
		input  latch,
		output cap_token,
		output cap_data
	);

	modport sink (
		input act,
		input data,
		input latch,
		input cap_token,
		input cap_data
	);

endinterface

/* hw/usb_token_rx.sv */
`include "usb_pkt_consts.svh"

module usb_token_rx (
	input  logic                phy_clk,
	input  logic                reset_2,
	usb_rx_if.sink              rx,
	output logic                tok_done,
	output usb_pkt_pkg::token_t tok,
	output logic                tok_crc_ok
);

	// bytes seen since cap_token went high
	logic [1:0] cnt;
	// first token byte
	usb_pkt_pkg::usb_byte_t b0;
	logic take;
	// crc input is {endp, addr} with addr[0] first on the wire
	logic [10:0] crc_bits;

	assign take = rx.cap_token && rx.latch;
	assign crc_bits = {rx.data[2:0], b0};

	// crc5 over the 11 field bits, lsb first
	// the result comes back complemented and in the bit order of byte two
	function automatic logic [4:0] crc5_calc(input logic [10:0] bits);
		logic [4:0] c;
		c = `USB_CRC5_INIT;
		for (int i = 0; i < 11; i++) begin
			if (bits[i] ^ c[0])
				c = (c >> 1) ^ `USB_CRC5_POLY;
			else
				c = c >> 1;
		end
		return ~c;
	endfunction

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			cnt <= 2'd0;
			tok_done <= 1'b0;
		end else begin
			// done one cycle after the second byte
			tok_done <= take && (cnt == 2'd1);
			if (!rx.cap_token)
				cnt <= 2'd0;
			else if (take && cnt != 2'd2)
				cnt <= cnt + 2'd1;
		end
	end

	always_ff @(posedge phy_clk) begin
		if (take && cnt == 2'd0)
			b0 <= rx.data;
		if (take && cnt == 2'd1) begin
			// addr sits in byte one, endp straddles both bytes
			tok.addr <= b0[6:0];
			tok.endp <= {rx.data[2:0], b0[7]};
			// crc5 field occupies the top five bits of byte two
			tok_crc_ok <= (crc5_calc(crc_bits) == rx.data[7:3]);
		end
	end

	// the controller must never hand one byte to both parsers
	a_one_owner: assert property (@(posedge phy_clk) disable iff (!reset_2)
		rx.latch |-> !(rx.cap_token && rx.cap_data));

endmodule

/* hw/usb_data_rx.sv */
`include "usb_pkt_consts.svh"

module usb_data_rx (
	input  logic                   phy_clk,
	input  logic                   reset_2,
	usb_rx_if.sink                 rx,
	input  logic                   wr_allow,
	output logic [`USB_BUF_AW-1:0] buf_in_addr,
	output usb_pkt_pkg::usb_byte_t buf_in_data,
	output logic                   buf_in_wren,
	output logic                   data_done,
	output logic [`USB_LEN_W-1:0]  data_len,
	output logic                   data_crc_ok
);

	// bytes latched in this packet
	logic [`USB_LEN_W-1:0] cnt;
	// index of the byte that leaves the delay line
	logic [`USB_LEN_W-1:0] out_idx;
	logic [`USB_LEN_W-1:0] wr_idx;
	// running crc plus the two previous states
	logic [15:0] crc;
	logic [15:0] crc_1;
	logic [15:0] crc_2;
	// two-deep delay line so the crc bytes never reach the buffer
	usb_pkt_pkg::usb_byte_t dly_new;
	usb_pkt_pkg::usb_byte_t dly_old;
	logic take;
	logic full;

	assign take = rx.cap_data && rx.latch;
	assign full = (cnt >= `USB_LEN_W'(2));
	assign out_idx = cnt - `USB_LEN_W'(2);
	assign buf_in_addr = wr_idx[`USB_BUF_AW-1:0];

	// reflected crc16 over one byte, lsb first
	function automatic logic [15:0] crc16_next(input logic [15:0] c_in,
		input usb_pkt_pkg::usb_byte_t b);
		logic [15:0] c;
		c = c_in;
		for (int i = 0; i < 8; i++) begin
			if (b[i] ^ c[0])
				c = (c >> 1) ^ `USB_CRC16_POLY;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			cnt <= '0;
			buf_in_wren <= 1'b0;
			data_done <= 1'b0;
		end else begin
			// write only once the line is full and the index fits
			buf_in_wren <= take && full && wr_allow && (out_idx < `USB_MAX_PAYLOAD);
			// eop seen while still capturing
			data_done <= rx.cap_data && !rx.act;
			if (!rx.cap_data)
				cnt <= '0;
			else if (take && cnt != '1)
				cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge phy_clk) begin
		if (!rx.cap_data) begin
			crc <= `USB_CRC16_INIT;
		end else if (take) begin
			crc <= crc16_next(crc, rx.data);
			crc_1 <= crc;
			crc_2 <= crc_1;
			dly_new <= rx.data;
			dly_old <= dly_new;
		end
		if (take) begin
			wr_idx <= out_idx;
			buf_in_data <= dly_old;
		end
		if (rx.cap_data && !rx.act) begin
			data_len <= out_idx;
			// crc bytes come low byte first and complemented
			data_crc_ok <= full && ({dly_new, dly_old} == ~crc_2);
		end
	end

	// oversized packets must stop at the buffer end
	a_wr_in_range: assert property (@(posedge phy_clk) disable iff (!reset_2)
		buf_in_wren |-> (wr_idx < `USB_MAX_PAYLOAD));

endmodule

/* hw/usb_pkt_ctrl.sv */
`include "usb_pkt_consts.svh"

module usb_pkt_ctrl (
	input  logic                   phy_clk,
	input  logic                   reset_2,
	usb_rx_if.ctrl                 rx,
	input  logic [`USB_DEV_AW-1:0] dev_addr,
	input  logic                   buf_in_ready,
	input  logic                   tok_done,
	input  logic                   tok_crc_ok,
	input  usb_pkt_pkg::token_t    tok,
	input  logic                   data_done,
	input  logic                   data_crc_ok,
	input  logic [`USB_LEN_W-1:0]  data_len,
	output logic                   wr_allow,
	output logic [`USB_EP_W-1:0]   sel_endp,
	output logic                   buf_in_commit,
	output logic [`USB_LEN_W-1:0]  buf_in_commit_len,
	input  logic                   buf_in_commit_ack,
	output logic                   tx_start,
	output usb_pkt_pkg::pid_t      tx_pid,
	input  logic                   tx_done,
	output logic                   err_crc_pid,
	output logic                   err_crc_tok,
	output logic                   err_crc_pkt
);

	typedef enum logic [2:0] {
		ST_IDLE, ST_TOK, ST_DATA, ST_COMMIT, ST_RELEASE, ST_TX, ST_WAIT_EOP
	} state_t;

	state_t state;
	usb_pkt_pkg::pid_t pid_in;
	usb_pkt_pkg::pid_t pid_cur;
	usb_pkt_pkg::pkt_kind_t kind;
	logic pid_ok;
	logic addr_match;
	// last good OUT/SETUP token was for us
	logic tok_armed;
	// copy of tok_armed and buffer-ready taken at the data pid
	logic data_armed;
	logic rdy_l;

	function automatic usb_pkt_pkg::pkt_kind_t classify(input usb_pkt_pkg::pid_t p);
		case (p)
			usb_pkt_pkg::PID_OUT, usb_pkt_pkg::PID_IN, usb_pkt_pkg::PID_SOF,
			usb_pkt_pkg::PID_SETUP, usb_pkt_pkg::PID_PING:
				return usb_pkt_pkg::KIND_TOKEN;
			usb_pkt_pkg::PID_DATA0, usb_pkt_pkg::PID_DATA1, usb_pkt_pkg::PID_DATA2,
			usb_pkt_pkg::PID_DATAM:
				return usb_pkt_pkg::KIND_DATA;
			usb_pkt_pkg::PID_ACK, usb_pkt_pkg::PID_NAK, usb_pkt_pkg::PID_STALL,
			usb_pkt_pkg::PID_NYET:
				return usb_pkt_pkg::KIND_HAND;
			usb_pkt_pkg::PID_PREERR, usb_pkt_pkg::PID_SPLIT, usb_pkt_pkg::PID_LPM:
				return usb_pkt_pkg::KIND_SPEC;
			default:
				return usb_pkt_pkg::KIND_UNDEF;
		endcase
	endfunction

	// upper nibble of the pid byte is the complement of the lower one
	assign pid_in = usb_pkt_pkg::pid_t'(rx.data[3:0]);
	assign pid_ok = (rx.data[7:4] == ~rx.data[3:0]);
	assign kind = classify(pid_in);
	assign addr_match = (tok.addr == dev_addr);

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			state <= ST_IDLE;
			rx.cap_token <= 1'b0;
			rx.cap_data <= 1'b0;
			wr_allow <= 1'b0;
			sel_endp <= '0;
			buf_in_commit <= 1'b0;
			tx_start <= 1'b0;
			tok_armed <= 1'b0;
			data_armed <= 1'b0;
			err_crc_pid <= 1'b0;
			err_crc_tok <= 1'b0;
			err_crc_pkt <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			// capture windows close at eop
			if (!rx.act) begin
				rx.cap_token <= 1'b0;
				rx.cap_data <= 1'b0;
			end
			case (state)
				ST_IDLE: begin
					if (rx.act && rx.latch) begin
						if (!pid_ok) begin
							err_crc_pid <= 1'b1;
							state <= ST_WAIT_EOP;
						end else if (kind == usb_pkt_pkg::KIND_TOKEN) begin
							pid_cur <= pid_in;
							rx.cap_token <= 1'b1;
							state <= ST_TOK;
						end else if (kind == usb_pkt_pkg::KIND_DATA) begin
							rx.cap_data <= 1'b1;
							// write permission decided once for the whole packet
							wr_allow <= buf_in_ready && tok_armed;
							rdy_l <= buf_in_ready;
							data_armed <= tok_armed;
							tok_armed <= 1'b0;
							state <= ST_DATA;
						end else begin
							// host handshakes and special pids are skipped
							state <= ST_WAIT_EOP;
						end
					end
				end
				ST_TOK: begin
					if (tok_done) begin
						if (!tok_crc_ok) begin
							err_crc_tok <= 1'b1;
							tok_armed <= 1'b0;
						end else if (pid_cur != usb_pkt_pkg::PID_SOF) begin
							tok_armed <= addr_match && (pid_cur == usb_pkt_pkg::PID_OUT ||
								pid_cur == usb_pkt_pkg::PID_SETUP);
							// endpoint only follows tokens sent to us
							if (addr_match)
								sel_endp <= tok.endp;
						end
						state <= ST_WAIT_EOP;
					end else if (!rx.act) begin
						// short token
						state <= ST_IDLE;
					end
				end
				ST_DATA: begin
					if (data_done) begin
						wr_allow <= 1'b0;
						state <= ST_IDLE;
						if (data_armed && !data_crc_ok) begin
							err_crc_pkt <= 1'b1;
						end else if (data_armed && rdy_l) begin
							buf_in_commit <= 1'b1;
							buf_in_commit_len <= data_len;
							state <= ST_COMMIT;
						end else if (data_armed) begin
							// buffer busy at the pid so nak without commit
							tx_pid <= usb_pkt_pkg::PID_NAK;
							tx_start <= 1'b1;
							state <= ST_TX;
						end
					end
				end
				ST_COMMIT: begin
					// hold the request until the buffer side answers
					if (buf_in_commit_ack) begin
						buf_in_commit <= 1'b0;
						state <= ST_RELEASE;
					end
				end
				ST_RELEASE: begin
					if (!buf_in_commit_ack) begin
						tx_pid <= usb_pkt_pkg::PID_ACK;
						tx_start <= 1'b1;
						state <= ST_TX;
					end
				end
				ST_TX: begin
					if (tx_done)
						state <= ST_IDLE;
				end
				ST_WAIT_EOP: begin
					if (!rx.act)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// four-phase request must not drop before the ack
	a_commit_hold: assert property (@(posedge phy_clk) disable iff (!reset_2)
		(buf_in_commit && !buf_in_commit_ack) |=> buf_in_commit);

endmodule

/* hw/usb_hand_tx.sv */
`include "usb_pkt_consts.svh"

module usb_hand_tx (
	input  logic                   phy_clk,
	input  logic                   reset_2,
	input  logic                   tx_start,
	input  usb_pkt_pkg::pid_t      tx_pid,
	input  logic                   out_cts,
	input  logic                   out_nxt,
	output usb_pkt_pkg::usb_byte_t out_byte,
	output logic                   out_latch,
	output logic                   out_stp,
	output logic                   tx_done
);

	typedef enum logic [1:0] {
		S_IDLE, S_CTS, S_NXT
	} state_t;

	state_t state;

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			state <= S_IDLE;
			out_latch <= 1'b0;
			out_stp <= 1'b0;
			tx_done <= 1'b0;
		end else begin
			out_stp <= 1'b0;
			tx_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (tx_start)
						state <= S_CTS;
				end
				S_CTS: begin
					// phy free to accept a transmit command
					if (out_cts) begin
						out_latch <= 1'b1;
						state <= S_NXT;
					end
				end
				S_NXT: begin
					// phy took the byte so stop the packet
					if (out_nxt) begin
						out_latch <= 1'b0;
						out_stp <= 1'b1;
						tx_done <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// txcmd nibble on top and the handshake pid below
	always_ff @(posedge phy_clk) begin
		if (tx_start && state == S_IDLE)
			out_byte <= {`ULPI_TXCMD, tx_pid};
	end

	a_stp_alone: assert property (@(posedge phy_clk) disable iff (!reset_2)
		out_stp |-> !out_latch);

endmodule

/* hw/usb_pkt_top.sv */
`include "usb_pkt_consts.svh"

module usb_pkt_top (
	input  logic                   phy_clk,
	input  logic                   reset_2,
	// ulpi receive
	input  logic                   in_act,
	input  usb_pkt_pkg::usb_byte_t in_byte,
	input  logic                   in_latch,
	// ulpi transmit
	input  logic                   out_cts,
	input  logic                   out_nxt,
	output usb_pkt_pkg::usb_byte_t out_byte,
	output logic                   out_latch,
	output logic                   out_stp,
	// protocol layer
	output logic [`USB_EP_W-1:0]   sel_endp,
	output logic [`USB_BUF_AW-1:0] buf_in_addr,
	output usb_pkt_pkg::usb_byte_t buf_in_data,
	output logic                   buf_in_wren,
	input  logic                   buf_in_ready,
	output logic                   buf_in_commit,
	output logic [`USB_LEN_W-1:0]  buf_in_commit_len,
	input  logic                   buf_in_commit_ack,
	input  logic [`USB_DEV_AW-1:0] dev_addr,
	// sticky status
	output logic                   err_crc_pid,
	output logic                   err_crc_tok,
	output logic                   err_crc_pkt
);

	logic tok_done;
	logic tok_crc_ok;
	usb_pkt_pkg::token_t tok;
	logic data_done;
	logic data_crc_ok;
	logic [`USB_LEN_W-1:0] data_len;
	logic wr_allow;
	logic tx_start;
	usb_pkt_pkg::pid_t tx_pid;
	logic tx_done;

	usb_rx_if u_rx ();

	// receive stream enters the shared bus here
	assign u_rx.act = in_act;
	assign u_rx.data = in_byte;
	assign u_rx.latch = in_latch;

	usb_pkt_ctrl u_ctrl (
		.phy_clk(phy_clk), .reset_2(reset_2), .rx(u_rx.ctrl), .dev_addr(dev_addr),
		.buf_in_ready(buf_in_ready), .tok_done(tok_done), .tok_crc_ok(tok_crc_ok),
		.tok(tok), .data_done(data_done), .data_crc_ok(data_crc_ok), .data_len(data_len),
		.wr_allow(wr_allow), .sel_endp(sel_endp), .buf_in_commit(buf_in_commit),
		.buf_in_commit_len(buf_in_commit_len), .buf_in_commit_ack(buf_in_commit_ack),
		.tx_start(tx_start), .tx_pid(tx_pid), .tx_done(tx_done),
		.err_crc_pid(err_crc_pid), .err_crc_tok(err_crc_tok), .err_crc_pkt(err_crc_pkt)
	);

	usb_token_rx u_token_rx (
		.phy_clk(phy_clk), .reset_2(reset_2), .rx(u_rx.sink),
		.tok_done(tok_done), .tok(tok), .tok_crc_ok(tok_crc_ok)
	);

	usb_data_rx u_data_rx (
		.phy_clk(phy_clk), .reset_2(reset_2), .rx(u_rx.sink), .wr_allow(wr_allow),
		.buf_in_addr(buf_in_addr), .buf_in_data(buf_in_data), .buf_in_wren(buf_in_wren),
		.data_done(data_done), .data_len(data_len), .data_crc_ok(data_crc_ok)
	);

	usb_hand_tx u_hand_tx (
		.phy_clk(phy_clk), .reset_2(reset_2), .tx_start(tx_start), .tx_pid(tx_pid),
		.out_cts(out_cts), .out_nxt(out_nxt), .out_byte(out_byte),
		.out_latch(out_latch), .out_stp(out_stp), .tx_done(tx_done)
	);

endmodule

/* verif/usb_pkt_tb.sv */
`include "usb_pkt_consts.svh"

module usb_pkt_tb;

	logic phy_clk;
	logic reset_2;
	logic in_act;
	usb_pkt_pkg::usb_byte_t in_byte;
	logic in_latch;
	logic out_cts;
	logic out_nxt;
	usb_pkt_pkg::usb_byte_t out_byte;
	logic out_latch;
	logic out_stp;
	logic [`USB_EP_W-1:0] sel_endp;
	logic [`USB_BUF_AW-1:0] buf_in_addr;
	usb_pkt_pkg::usb_byte_t buf_in_data;
	logic buf_in_wren;
	logic buf_in_ready;
	logic buf_in_commit;
	logic [`USB_LEN_W-1:0] buf_in_commit_len;
	logic buf_in_commit_ack;
	logic [`USB_DEV_AW-1:0] dev_addr;
	logic err_crc_pid;
	logic err_crc_tok;
	logic err_crc_pkt;

	logic [31:0] lcg_state;
	int errors;
	int test_err;
	int tests_run;
	int tests_bad;
	// event counters kept by the bus monitor
	int wr_cnt;
	int commit_cnt;
	int latch_cnt;
	int stp_cnt;
	logic commit_q;
	logic latch_q;
	// sticky data crc error expected so far
	logic pkt_err_exp;
	logic [`USB_LEN_W-1:0] commit_len_seen;
	usb_pkt_pkg::usb_byte_t hand_seen;
	usb_pkt_pkg::usb_byte_t mem_seen [0:`USB_MAX_PAYLOAD-1];
	usb_pkt_pkg::usb_byte_t payload [$];
	usb_pkt_pkg::usb_byte_t pkt [$];

	usb_pkt_top u_dut (.*);

	always #10 phy_clk = ~phy_clk;

	// model of the endpoint buffer and the phy transmit side
	always @(posedge phy_clk) begin
		if (!reset_2) begin
			commit_q = 1'b0;
			latch_q = 1'b0;
		end else begin
			if (buf_in_wren) begin
				wr_cnt++;
				mem_seen[buf_in_addr] = buf_in_data;
			end
			if (buf_in_commit && !commit_q) begin
				commit_cnt++;
				commit_len_seen = buf_in_commit_len;
			end
			if (out_latch && !latch_q) begin
				latch_cnt++;
				hand_seen = out_byte;
			end
			if (out_stp)
				stp_cnt++;
			commit_q = buf_in_commit;
			latch_q = out_latch;
		end
	end

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {16'h0, lcg_state[31:16]};
	endfunction

	task automatic tick();
		@(posedge phy_clk);
		#2;
	endtask

	task automatic check_byte(input string name, input usb_pkt_pkg::usb_byte_t got,
		input usb_pkt_pkg::usb_byte_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
			test_err++;
		end
	endtask

	task automatic check_len(input string name, input logic [`USB_LEN_W-1:0] got,
		input logic [`USB_LEN_W-1:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
			test_err++;
		end
	endtask

	task automatic check_endp(input string name, input logic [`USB_EP_W-1:0] got,
		input logic [`USB_EP_W-1:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
			test_err++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
			test_err++;
		end
	endtask

	// usb crc5 with poly x^5+x^2+1 over the bits in wire order
	// the field comes back as it sits in byte two
	function automatic logic [4:0] crc5_field(input logic [10:0] bits);
		logic [4:0] c;
		logic [4:0] f;
		logic fb;
		c = `USB_CRC5_INIT;
		for (int i = 0; i < 11; i++) begin
			fb = bits[i] ^ c[4];
			c = {c[3:0], 1'b0};
			if (fb)
				c = c ^ 5'h05;
		end
		// msb of the inverted remainder goes out first
		for (int k = 0; k < 5; k++)
			f[k] = ~c[4 - k];
		return f;
	endfunction

	// usb crc16 with poly 8005 over the payload
	// returned as the little endian pair on the wire
	function automatic logic [15:0] crc16_field();
		logic [15:0] c;
		logic [15:0] f;
		logic fb;
		c = `USB_CRC16_INIT;
		foreach (payload[j]) begin
			for (int i = 0; i < 8; i++) begin
				fb = payload[j][i] ^ c[15];
				c = {c[14:0], 1'b0};
				if (fb)
					c = c ^ 16'h8005;
			end
		end
		for (int k = 0; k < 16; k++)
			f[k] = ~c[15 - k];
		return f;
	endfunction

	// one packet on the ulpi receive side with random latch gaps
	task automatic send_packet();
		for (int i = 0; i < pkt.size(); i++) begin
			if (i != 0 && rand_next() % 4 == 0) begin
				in_latch = 1'b0;
				tick();
			end
			in_act = 1'b1;
			in_byte = pkt[i];
			in_latch = 1'b1;
			tick();
		end
		in_latch = 1'b0;
		in_act = 1'b0;
		repeat (4) tick();
	endtask

	task automatic send_token(input usb_pkt_pkg::pid_t pid, input logic [6:0] addr,
		input logic [3:0] endp, input bit corrupt);
		logic [4:0] f;
		f = crc5_field({endp, addr});
		pkt = {};
		pkt.push_back({~pid, pid});
		pkt.push_back({endp[0], addr});
		pkt.push_back({f, endp[3:1]});
		if (corrupt)
			pkt[2] = pkt[2] ^ 8'h80;
		send_packet();
	endtask

	// phy and buffer side until the handshake ends or a quiet window passes
	task automatic respond(input bit expect_reply);
		int cyc;
		int ack_dly;
		int stp0;
		stp0 = stp_cnt;
		ack_dly = rand_next() % 6;
		cyc = 0;
		while (cyc < (expect_reply ? 400 : 40) && !(expect_reply && stp_cnt != stp0)) begin
			tick();
			cyc++;
			out_cts = (rand_next() % 4) != 0;
			out_nxt = (rand_next() % 3) != 0;
			if (buf_in_commit && !buf_in_commit_ack) begin
				if (ack_dly == 0)
					buf_in_commit_ack = 1'b1;
				else
					ack_dly--;
			end else if (!buf_in_commit && buf_in_commit_ack) begin
				buf_in_commit_ack = 1'b0;
			end
		end
		out_cts = 1'b0;
		out_nxt = 1'b0;
		if (expect_reply && stp_cnt == stp0) begin
			$display("timeout at %0t: no handshake stop seen after the data packet", $time);
			errors++;
			test_err++;
		end
		repeat (2) tick();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_err != 0)
			tests_bad++;
		$display("%s: %s", name, (test_err == 0) ? "ok" : "FAIL");
		test_err = 0;
	endtask

	// token then data with the expected ack, nak or silence
	task automatic run_transfer(input string name, input usb_pkt_pkg::pid_t tpid,
		input bit to_us, input bit ready, input bit corrupt, input int len);
		logic [6:0] addr;
		logic [3:0] endp;
		logic [3:0] prev_endp;
		logic [15:0] crc;
		int wr0;
		int cm0;
		int lt0;
		int st0;
		bit reply;
		usb_pkt_pkg::pid_t dpid;
		prev_endp = sel_endp;
		endp = 4'(rand_next());
		addr = to_us ? dev_addr : dev_addr ^ 7'(rand_next() % 127 + 1);
		send_token(tpid, addr, endp, 1'b0);
		check_endp("sel_endp", sel_endp, to_us ? endp : prev_endp);
		wr0 = wr_cnt;
		cm0 = commit_cnt;
		lt0 = latch_cnt;
		st0 = stp_cnt;
		payload = {};
		for (int i = 0; i < len; i++)
			payload.push_back(8'(rand_next()));
		crc = crc16_field();
		dpid = (rand_next() % 2) ? usb_pkt_pkg::PID_DATA1 : usb_pkt_pkg::PID_DATA0;
		pkt = payload;
		pkt.push_front({~dpid, dpid});
		pkt.push_back(crc[7:0]);
		pkt.push_back(crc[15:8]);
		if (corrupt)
			pkt[pkt.size() - 1] = pkt[pkt.size() - 1] ^ 8'h01;
		check_flag("err_crc_pkt", err_crc_pkt, pkt_err_exp);
		buf_in_ready = ready;
		send_packet();
		reply = to_us && !corrupt;
		respond(reply);
		if (!(to_us && corrupt))
			check_len("buf_in_wren count", `USB_LEN_W'(wr_cnt - wr0),
				`USB_LEN_W'((to_us && ready) ? len : 0));
		check_len("buf_in_commit count", `USB_LEN_W'(commit_cnt - cm0),
			`USB_LEN_W'((reply && ready) ? 1 : 0));
		check_len("out_latch count", `USB_LEN_W'(latch_cnt - lt0), `USB_LEN_W'(reply ? 1 : 0));
		check_len("out_stp count", `USB_LEN_W'(stp_cnt - st0), `USB_LEN_W'(reply ? 1 : 0));
		if (reply) begin
			check_byte("out_byte", hand_seen, ready ? 8'h42 : 8'h4a);
			if (ready) begin
				check_len("buf_in_commit_len", commit_len_seen, `USB_LEN_W'(len));
				for (int i = 0; i < len; i++)
					check_byte($sformatf("buf_in_data[%0d]", i), mem_seen[i], payload[i]);
			end
		end
		if (to_us && corrupt)
			pkt_err_exp = 1'b1;
		check_flag("err_crc_pkt", err_crc_pkt, pkt_err_exp);
		finish_test(name);
	endtask

	initial begin
		phy_clk = 1'b0;
		reset_2 = 1'b0;
		in_act = 1'b0;
		in_byte = 8'h00;
		in_latch = 1'b0;
		out_cts = 1'b0;
		out_nxt = 1'b0;
		buf_in_ready = 1'b0;
		buf_in_commit_ack = 1'b0;
		lcg_state = 32'hde63;
		dev_addr = 7'(rand_next());
		errors = 0;
		test_err = 0;
		tests_run = 0;
		tests_bad = 0;
		wr_cnt = 0;
		commit_cnt = 0;
		latch_cnt = 0;
		stp_cnt = 0;
		pkt_err_exp = 1'b0;
		repeat (16) @(posedge phy_clk);
		#2;
		reset_2 = 1'b1;
		tick();

		// outputs sit at their idle values out of reset
		check_flag("buf_in_wren", buf_in_wren, 1'b0);
		check_flag("buf_in_commit", buf_in_commit, 1'b0);
		check_flag("out_latch", out_latch, 1'b0);
		check_flag("out_stp", out_stp, 1'b0);
		check_flag("err_crc_pid", err_crc_pid, 1'b0);
		check_flag("err_crc_tok", err_crc_tok, 1'b0);
		check_flag("err_crc_pkt", err_crc_pkt, 1'b0);
		finish_test("reset values");

		run_transfer("out ack", usb_pkt_pkg::PID_OUT, 1, 1, 0, 1 + rand_next() % 64);
		run_transfer("out nak", usb_pkt_pkg::PID_OUT, 1, 0, 0, rand_next() % 65);
		run_transfer("other address", usb_pkt_pkg::PID_OUT, 0, 1, 0, rand_next() % 65);
		run_transfer("setup zero length", usb_pkt_pkg::PID_SETUP, 1, 1, 0, 0);

		// bad token crc and then a pid whose halves disagree
		check_flag("err_crc_tok", err_crc_tok, 1'b0);
		send_token(usb_pkt_pkg::PID_OUT, dev_addr, 4'(rand_next()), 1'b1);
		check_flag("err_crc_tok", err_crc_tok, 1'b1);
		check_flag("err_crc_pid", err_crc_pid, 1'b0);
		pkt = {8'h32};
		send_packet();
		check_flag("err_crc_pid", err_crc_pid, 1'b1);
		finish_test("bad token and pid");

		run_transfer("bad data crc", usb_pkt_pkg::PID_OUT, 1, 1, 1, rand_next() % 65);

		for (int n = 0; n < 10; n++) begin
			run_transfer($sformatf("random %0d", n),
				(rand_next() % 2) ? usb_pkt_pkg::PID_SETUP : usb_pkt_pkg::PID_OUT,
				(rand_next() % 4) != 0, (rand_next() % 3) != 0, (rand_next() % 5) == 0,
				rand_next() % 65);
		end

		$display("tests run %0d, tests with errors %0d, checks failed %0d",
			tests_run, tests_bad, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* usb_pkt.f */
+incdir+include
hw/usb_pkt_pkg.sv
hw/usb_rx_if.sv
hw/usb_token_rx.sv
hw/usb_data_rx.sv
hw/usb_pkt_ctrl.sv
hw/usb_hand_tx.sv
hw/usb_pkt_top.sv
verif/usb_pkt_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= usb_pkt_tb
FILELIST ?= usb_pkt.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

# build, run, and pass only when the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf $(BUILD_DIR)
